// File: vlog.f
+incdir+source
source/nib_fifo_pkg.sv
source/flush_pkg.sv
source/nib_store.sv
source/flush_ctrl.sv
source/nib_fifo_top.sv
dv/nib_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the nibble FIFO testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=nib_fifo_sim
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f vlog.f \
  --top-module nib_fifo_tb \
  --Mdir "$OBJ_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

// File: dv/nib_fifo_tb.sv
// Self-checking testbench for the nibble FIFO top level.
// Scenario rows run back to back, so nibbles left over by one row feed the next.
// Rows must keep the model within 32 nibbles and flush only while data is stored.

`default_nettype none

`include "nib_fifo_defines.svh"

module nib_fifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS = 16;

  // Cycles any single wait may take before it is treated as a hang
  localparam int WAIT_LIMIT = 64;

  // One scenario row
  typedef struct packed {
    // Nibbles written before the row's reads or flush
    logic [5:0] n_wr;
    logic       do_flush;
    // Nibbles written under flush_req with the first one in the first flush cycle
    logic [5:0] n_fl_wr;
    // full right after the first writes
    logic       exp_full;
    // empty once the row has finished
    logic       exp_empty;
  } row_s;

  logic                  clk;
  logic                  rst;
  logic                  wr;
  nib_fifo_pkg::nibble_t wr_data;
  logic                  rd;
  logic                  flush_req;
  nib_fifo_pkg::word_t   rd_data;
  logic                  data_avail;
  logic                  flush_done;
  logic                  full;
  logic                  empty;

  row_s scen [NUM_ROWS];

  // Reference model with the oldest nibble at the front
  nib_fifo_pkg::nibble_t model_q [$];

  // Level that drive_cycle puts on flush_req
  logic flush_lvl;

  int    mismatches;
  int    timeouts;
  string where;

  nib_fifo_top dut (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .wr_data    (wr_data),
    .rd         (rd),
    .flush_req  (flush_req),
    .rd_data    (rd_data),
    .data_avail (data_avail),
    .flush_done (flush_done),
    .full       (full),
    .empty      (empty)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Columns are n_wr, do_flush, n_fl_wr, exp_full, exp_empty
  // Model occupancy after each row is noted on the right
  function automatic void load_scenarios();
    scen[0]  = '{6'd8,  1'b0, 6'd0, 1'b0, 1'b1};  // 0
    scen[1]  = '{6'd32, 1'b0, 6'd0, 1'b1, 1'b1};  // 0 after four words
    scen[2]  = '{6'd11, 1'b1, 6'd0, 1'b0, 1'b1};  // 0 after one word plus 3 nibbles
    scen[3]  = '{6'd10, 1'b1, 6'd1, 1'b0, 1'b1};  // 0 with the first-cycle write flushed
    scen[4]  = '{6'd5,  1'b1, 6'd4, 1'b0, 1'b0};  // 3 left behind the boundary
    scen[5]  = '{6'd2,  1'b1, 6'd0, 1'b0, 1'b1};  // 0
    scen[6]  = '{6'd3,  1'b0, 6'd0, 1'b0, 1'b0};  // 3 and no full word yet
    scen[7]  = '{6'd5,  1'b0, 6'd0, 1'b0, 1'b1};  // 0
    scen[8]  = '{6'd20, 1'b0, 6'd0, 1'b0, 1'b0};  // 4
    scen[9]  = '{6'd13, 1'b1, 6'd3, 1'b0, 1'b0};  // 2
    scen[10] = '{6'd28, 1'b0, 6'd0, 1'b0, 1'b0};  // 6
    scen[11] = '{6'd2,  1'b0, 6'd0, 1'b0, 1'b1};  // 0
    scen[12] = '{6'd7,  1'b1, 6'd2, 1'b0, 1'b0};  // 1 after a flush of exactly one word
    scen[13] = '{6'd0,  1'b1, 6'd0, 1'b0, 1'b1};  // 0 after a single nibble flush
    scen[14] = '{6'd30, 1'b1, 6'd2, 1'b0, 1'b0};  // 1 after filling to 32 during the flush
    scen[15] = '{6'd7,  1'b0, 6'd0, 1'b0, 1'b1};  // 0
  endfunction

  // All strobes change right after the rising edge
  task automatic drive_cycle(input logic w, input nib_fifo_pkg::nibble_t d, input logic r);
    @(posedge clk);
    wr        <= w;
    wr_data   <= d;
    rd        <= r;
    flush_req <= flush_lvl;
  endtask

  task automatic expect_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      mismatches++;
      $display("FAIL %s got 0x%0h expected 0x%0h in %s", name, got, want, where);
    end
  endtask

  // Random nibble into both the model and the DUT
  task automatic push_nibble();
    nib_fifo_pkg::nibble_t d;
    d = nib_fifo_pkg::nibble_t'($urandom);
    model_q.push_back(d);
    drive_cycle(1'b1, d, 1'b0);
  endtask

  // Strobes must be idle while waiting, otherwise the flags move under us
  task automatic wait_data_avail();
    int n;
    n = 0;
    @(negedge clk);
    while (!data_avail && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!data_avail) begin
      timeouts++;
      $display("Timed out waiting for data_avail in %s", where);
    end
  endtask

  task automatic wait_flush_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!flush_done && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!flush_done) begin
      timeouts++;
      $display("Timed out waiting for flush_done in %s", where);
    end
  endtask

  // Reads one word that should carry the next k model nibbles
  // Oldest nibble sits in bits 3:0 and slots from k upward must read as zero
  task automatic read_word(input int k);
    nib_fifo_pkg::word_t want;
    int i;
    want = '0;
    for (i = 0; i < k; i++) begin
      want[i*`NIB_W +: `NIB_W] = model_q[i];
    end
    wait_data_avail();
    drive_cycle(1'b0, '0, 1'b1);
    // rd_data belongs to the same cycle as rd
    @(negedge clk);
    if (rd_data !== want) begin
      mismatches++;
      $display("FAIL rd_data got 0x%08h expected 0x%08h in %s", rd_data, want, where);
    end
    // Nibbles are still owed to any flush while this word is being read
    expect_flag("flush_done", flush_done, 1'b0);
    // The pop lands on this edge
    drive_cycle(1'b0, '0, 1'b0);
    for (i = 0; i < k; i++) begin
      void'(model_q.pop_front());
    end
  endtask

  task automatic run_row(input row_s r);
    int flush_rem;
    int i;
    int k;
    for (i = 0; i < int'(r.n_wr); i++) begin
      push_nibble();
    end
    drive_cycle(1'b0, '0, 1'b0);
    @(negedge clk);
    expect_flag("full", full, r.exp_full);
    // Outside a flush a word is ready once eight nibbles are stored
    expect_flag("data_avail", data_avail, model_q.size() >= `NIBS_PER_WORD);

    if (r.do_flush) begin
      flush_lvl = 1'b1;
      flush_rem = model_q.size();
      for (i = 0; i < int'(r.n_fl_wr); i++) begin
        push_nibble();
        // Only the write in the first flush cycle falls inside the boundary
        if (i == 0) begin
          flush_rem++;
        end
      end
      // With no flush writes this idle cycle is the first flush cycle
      drive_cycle(1'b0, '0, 1'b0);
      while (flush_rem > 0) begin
        k = (flush_rem < `NIBS_PER_WORD) ? flush_rem : `NIBS_PER_WORD;
        read_word(k);
        flush_rem -= k;
      end
      wait_flush_done();
      flush_lvl = 1'b0;
      // Second cycle lets the controller fall back to idle
      drive_cycle(1'b0, '0, 1'b0);
      drive_cycle(1'b0, '0, 1'b0);
    end else begin
      while (model_q.size() >= `NIBS_PER_WORD) begin
        read_word(`NIBS_PER_WORD);
      end
    end

    @(negedge clk);
    expect_flag("flush_done", flush_done, 1'b0);
    expect_flag("empty", empty, r.exp_empty);
    expect_flag("data_avail", data_avail, model_q.size() >= `NIBS_PER_WORD);
  endtask

  initial begin
    rst        = 1'b0;
    wr         = 1'b0;
    wr_data    = '0;
    rd         = 1'b0;
    flush_req  = 1'b0;
    flush_lvl  = 1'b0;
    mismatches = 0;
    timeouts   = 0;
    where      = "reset";
    void'($urandom(55));
    load_scenarios();

    repeat (2) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    expect_flag("empty", empty, 1'b1);
    expect_flag("full", full, 1'b0);
    expect_flag("data_avail", data_avail, 1'b0);
    expect_flag("flush_done", flush_done, 1'b0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      where = $sformatf("row %0d", r);
      run_row(scen[r]);
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/nib_fifo_top.sv
// Top of the width-converting FIFO, 4-bit writes and 32-bit reads with flush.
// Plain strobes only: wr must respect full and rd must wait for data_avail.
// rd_data is valid in the same cycle as rd.

`default_nettype none

module nib_fifo_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr,
  input  nib_fifo_pkg::nibble_t wr_data,
  input  logic                  rd,
  input  logic                  flush_req,
  output nib_fifo_pkg::word_t   rd_data,
  output logic                  data_avail,
  output logic                  flush_done,
  output logic                  full,
  output logic                  empty
);

  // Pointer and occupancy status from storage to control
  nib_fifo_pkg::store_status_s stat;

  // Pop strobe and length from control to storage
  flush_pkg::pop_cmd_s cmd;

  // Storage array, pointers, read window and flags
  nib_store u_store (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .wr_data (wr_data),
    .cmd     (cmd),
    .rd_data (rd_data),
    .stat    (stat),
    .full    (full),
    .empty   (empty)
  );

  // Flush boundary tracking and pop length selection
  flush_ctrl u_flush (
    .clk        (clk),
    .rst        (rst),
    .rd         (rd),
    .flush_req  (flush_req),
    .stat       (stat),
    .cmd        (cmd),
    .data_avail (data_avail),
    .flush_done (flush_done)
  );

endmodule

`default_nettype wire

// File: source/flush_ctrl.sv
// Flush control and read pacing for the nibble FIFO.
// flush_req must stay high until flush_done and only come while data is stored.
// All outputs are combinational from the state, the boundary and stat.

`default_nettype none

`include "nib_fifo_defines.svh"

module flush_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd,
  input  logic                        flush_req,
  input  nib_fifo_pkg::store_status_s stat,
  output flush_pkg::pop_cmd_s         cmd,
  output logic                        data_avail,
  output logic                        flush_done
);

  localparam int LEN_W = $clog2(`NIBS_PER_WORD) + 1;

  flush_pkg::flush_state_e state_q;

  // Write pointer seen in the first flush cycle
  // Everything below it belongs to the flush
  nib_fifo_pkg::ptr_t bound_q;

  // Nibbles still owed to the flush, from 0 to 32
  nib_fifo_pkg::ptr_t remaining;

  logic draining;
  logic flush_left;
  logic short_pop;

  // State and boundary
  // The boundary is taken from stat.wr_ptr, so a write in the first flush cycle
  // is included while later writes fall outside the flush
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= flush_pkg::FL_IDLE;
      bound_q <= '0;
    end else begin
      case (state_q)
        flush_pkg::FL_IDLE: begin
          if (flush_req) begin
            state_q <= flush_pkg::FL_DRAIN;
            bound_q <= stat.wr_ptr;
          end
        end
        flush_pkg::FL_DRAIN: begin
          // The requester drops flush_req once it has seen flush_done
          if (!flush_req) begin
            state_q <= flush_pkg::FL_IDLE;
          end
        end
      endcase
    end
  end

  assign draining  = (state_q == flush_pkg::FL_DRAIN);
  assign remaining = bound_q - stat.rd_ptr;

  // A partial word can be read only once the boundary is registered
  // During the first flush cycle reads fall back to the full-word rule
  assign flush_left = draining && (remaining != '0);
  assign short_pop  = flush_left && (remaining < nib_fifo_pkg::ptr_t'(`NIBS_PER_WORD));

  assign data_avail = (stat.count >= `CNT_W'(`NIBS_PER_WORD)) || flush_left;

  // Pop command
  // len always carries the pop length so the storage can zero the window above it
  always_comb begin
    cmd.pop = rd;
    if (short_pop) begin
      cmd.len = remaining[LEN_W-1:0];
    end else begin
      cmd.len = LEN_W'(`NIBS_PER_WORD);
    end
  end

  // Done once the read pointer has caught up with the boundary
  assign flush_done = flush_req && draining && (stat.rd_ptr == bound_q);

endmodule

`default_nettype wire

// File: source/nib_store.sv
// Nibble storage with a combinational 8-nibble read window.
// Writes when full and pops beyond the stored data are not checked.
// The window shows nibbles below cmd.len and zeros above them.

`default_nettype none

`include "nib_fifo_defines.svh"

module nib_store (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr,
  input  nib_fifo_pkg::nibble_t       wr_data,
  input  flush_pkg::pop_cmd_s         cmd,
  output nib_fifo_pkg::word_t         rd_data,
  output nib_fifo_pkg::store_status_s stat,
  output logic                        full,
  output logic                        empty
);

  // Index bits into the array, the pointer adds one wrap bit on top
  localparam int IDX_W = `PTR_W - 1;

  // Payload array, contents are don't-care until written
  nib_fifo_pkg::nibble_t mem [`CAP_NIBS];

  nib_fifo_pkg::ptr_t wr_ptr_q;
  nib_fifo_pkg::ptr_t rd_ptr_q;

  // Pointer value once this cycle's write is counted
  nib_fifo_pkg::ptr_t wr_ptr_next;

  assign wr_ptr_next = wr_ptr_q + nib_fifo_pkg::ptr_t'(wr);

  // Write side
  // The nibble lands in the array and the pointer moves at the same edge
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr_q[IDX_W-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr_q <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_next;
    end
  end

  // Read side
  // A pop removes cmd.len nibbles, which is 8 except at the tail of a flush
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_ptr_q <= '0;
    end else if (cmd.pop) begin
      rd_ptr_q <= rd_ptr_q + nib_fifo_pkg::ptr_t'(cmd.len);
    end
  end

  // Read window
  // Eight nibbles from the read pointer up, with the index wrapping at 32
  // Slots at or past cmd.len are forced to zero, which gives the flush padding
  always_comb begin
    logic [IDX_W-1:0] idx;
    rd_data = '0;
    for (int i = 0; i < `NIBS_PER_WORD; i++) begin
      idx = rd_ptr_q[IDX_W-1:0] + IDX_W'(i);
      if (i < int'(cmd.len)) begin
        rd_data[i*`NIB_W +: `NIB_W] = mem[idx];
      end
    end
  end

  // Flags
  // Same index with opposite wrap bits means the array is full
  assign full  = (wr_ptr_q == {~rd_ptr_q[IDX_W], rd_ptr_q[IDX_W-1:0]});
  assign empty = (wr_ptr_q == rd_ptr_q);

  // Status for the flush controller
  // The count leaves out the nibble being written now since it is not yet readable
  always_comb begin
    stat.wr_ptr = wr_ptr_next;
    stat.rd_ptr = rd_ptr_q;
    stat.count  = wr_ptr_q - rd_ptr_q;
  end

endmodule

`default_nettype wire

// File: source/flush_pkg.sv
// Types owned by the flush controller.
// The pop length field is sized for 1 to 8 nibbles per read.

`default_nettype none

`include "nib_fifo_defines.svh"

package flush_pkg;

  // Controller state
  // FL_DRAIN lasts from the edge after the request until the request drops
  typedef enum logic {
    FL_IDLE  = 1'b0,
    FL_DRAIN = 1'b1
  } flush_state_e;

  // Pop command sent to the storage
  // len is also what limits the read window, so it is valid even without pop
  typedef struct packed {
    logic                             pop;
    logic [$clog2(`NIBS_PER_WORD):0]  len;
  } pop_cmd_s;

endpackage

`default_nettype wire

// File: source/nib_fifo_pkg.sv
// Data-path types shared by the storage, the flush controller and the top.
// Widths come from the defines header and are not meant to be overridden.

`default_nettype none

`include "nib_fifo_defines.svh"

package nib_fifo_pkg;

  // One write beat
  typedef logic [`NIB_W-1:0] nibble_t;

  // One read word made of eight nibbles
  typedef logic [`WORD_W-1:0] word_t;

  // Storage pointer, top bit is the wrap flag
  typedef logic [`PTR_W-1:0] ptr_t;

  // Status the storage hands to the flush controller every cycle
  typedef struct packed {
    // Write pointer including any write accepted in this cycle
    ptr_t                  wr_ptr;
    // Read pointer as registered
    ptr_t                  rd_ptr;
    // Occupancy before this cycle's write lands
    logic [`CNT_W-1:0]     count;
  } store_status_s;

endpackage

`default_nettype wire

// File: source/nib_fifo_defines.svh
// Sizing constants for the nibble-in, word-out FIFO.
// Only a 4-bit write side and a 32-bit read side are supported.
// The pointer and count widths below are tied to a 32-nibble capacity.

`ifndef NIB_FIFO_DEFINES_SVH
`define NIB_FIFO_DEFINES_SVH

// Width of one write beat
`define NIB_W 4

// Width of one read word
`define WORD_W 32

// Nibbles packed into each read word, oldest in the low bits
`define NIBS_PER_WORD 8

// Total storage, 128 bits held as nibbles
`define CAP_NIBS 32

// Five index bits plus one wrap bit, so full and empty can be told apart
`define PTR_W 6

// Occupancy runs from 0 to 32 inclusive, which needs six bits
`define CNT_W 6

`endif
